// File: files.f
src/ooo_params_pkg.sv
src/ooo_types_pkg.sv
src/issue_if.sv
src/reservation_station.sv
src/phys_reg_file.sv
src/exec_unit.sv
src/issue_core.sv
tb/tb_issue_core.sv

// File: src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import ooo_params_pkg::*, ooo_types_pkg::*;
#(
    parameter int mul_latency = 3
) (
    input  logic              clk,
    input  logic              rst,
    issue_if.exec_unit        iss,
    output logic [preg_w-1:0] rd1_tag,
    output logic [preg_w-1:0] rd2_tag,
    input  logic [xlen-1:0]   rd1_data,
    input  logic [xlen-1:0]   rd2_data,
    output cdb_t              cdb
);

    localparam int half = xlen / 2;
    localparam int last = mul_latency - 2;

    logic [xlen-1:0]   imm_ext;
    logic [xlen-1:0]   opa;
    logic [xlen-1:0]   opb;
    logic [xlen-1:0]   alu_result;
    logic              alu_done;
    logic              mul_start;
    logic [xlen-1:0]   pp_lo;
    logic [half-1:0]   pp_hi;

    // Multiplier stages, valid bit is control, tag and partial products are payload
    logic [last:0]     mul_v;
    logic [preg_w-1:0] mul_tag [mul_latency-1];
    logic [xlen-1:0]   mul_lo  [mul_latency-1];
    logic [half-1:0]   mul_hi  [mul_latency-1];

    // CDB register
    logic              cdb_valid_q;
    logic [preg_w-1:0] cdb_tag_q;
    logic [xlen-1:0]   cdb_data_q;

    // Operand fetch from the register file
    assign rd1_tag = iss.src1;
    assign rd2_tag = iss.src2;
    assign imm_ext = {{(xlen - imm_w){iss.imm[imm_w-1]}}, iss.imm};
    assign opa     = rd1_data;
    assign opb     = iss.use_imm ? imm_ext : rd2_data;

    assign alu_done  = iss.valid && (iss.op != op_mul);
    assign mul_start = iss.valid && (iss.op == op_mul);

    always_comb begin
        case (iss.op)
            op_add, op_addi: alu_result = opa + opb;
            op_sub:          alu_result = opa - opb;
            op_and:          alu_result = opa & opb;
            op_xor:          alu_result = opa ^ opb;
            default:         alu_result = '0;
        endcase
    end

    // Low word of the product split in two partial products
    // Upper half term only reaches bits above half
    assign pp_lo = opa * opb[half-1:0];
    assign pp_hi = opa[half-1:0] * opb[xlen-1:half];

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_v <= '0;
        end else begin
            mul_v[0] <= mul_start;
            for (int s = 1; s <= last; s++) begin
                mul_v[s] <= mul_v[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        mul_tag[0] <= iss.dest;
        mul_lo[0]  <= pp_lo;
        mul_hi[0]  <= pp_hi;
        for (int s = 1; s <= last; s++) begin
            mul_tag[s] <= mul_tag[s-1];
            mul_lo[s]  <= mul_lo[s-1];
            mul_hi[s]  <= mul_hi[s-1];
        end
    end

    // Result broadcast, one source per cycle by construction of the issue schedule
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= alu_done || mul_v[last];
        end
    end

    always_ff @(posedge clk) begin
        if (alu_done) begin
            cdb_tag_q  <= iss.dest;
            cdb_data_q <= alu_result;
        end else if (mul_v[last]) begin
            cdb_tag_q  <= mul_tag[last];
            cdb_data_q <= mul_lo[last] + {mul_hi[last], {half{1'b0}}};
        end
    end

    assign cdb = '{valid: cdb_valid_q, tag: cdb_tag_q, data: cdb_data_q};

    // Slot reservation in the station keeps the two completion paths apart
    a_one_completion: assert property (@(posedge clk) disable iff (rst)
        !(alu_done && mul_v[last]));

endmodule : exec_unit

// File: src/issue_core.sv
`timescale 1ns/1ps

module issue_core
    import ooo_params_pkg::*, ooo_types_pkg::*;
#(
    parameter int rs_depth    = 8,
    parameter int mul_latency = 3
) (
    input  logic              clk,
    input  logic              rst,
    // Renamed operations from the rename stage
    input  logic              dispatch_valid,
    input  op_e               dispatch_op,
    input  logic [preg_w-1:0] dispatch_src1,
    input  logic              dispatch_src1_ready,
    input  logic [preg_w-1:0] dispatch_src2,
    input  logic              dispatch_src2_ready,
    input  logic              dispatch_use_imm,
    input  logic [imm_w-1:0]  dispatch_imm,
    input  logic [preg_w-1:0] dispatch_dest,
    output logic              dispatch_ready,
    // Register file preload, stands in for completed loads
    input  logic              preload_we,
    input  logic [preg_w-1:0] preload_tag,
    input  logic [xlen-1:0]   preload_data,
    // CDB as seen from outside
    output logic              result_valid,
    output logic [preg_w-1:0] result_tag,
    output logic [xlen-1:0]   result_data
);

    dispatch_t         disp;
    cdb_t              cdb;
    logic [preg_w-1:0] rd1_tag;
    logic [preg_w-1:0] rd2_tag;
    logic [xlen-1:0]   rd1_data;
    logic [xlen-1:0]   rd2_data;

    issue_if iss ();

    assign disp = '{op: dispatch_op, src1: dispatch_src1, src1_ready: dispatch_src1_ready,
                    src2: dispatch_src2, src2_ready: dispatch_src2_ready,
                    use_imm: dispatch_use_imm, imm: dispatch_imm, dest: dispatch_dest};

    assign result_valid = cdb.valid;
    assign result_tag   = cdb.tag;
    assign result_data  = cdb.data;

    reservation_station #(
        .rs_depth    (rs_depth),
        .mul_latency (mul_latency)
    ) i_reservation_station (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (dispatch_valid),
        .disp       (disp),
        .cdb        (cdb),
        .disp_ready (dispatch_ready),
        .iss        (iss.reservation_station)
    );

    phys_reg_file i_phys_reg_file (
        .clk          (clk),
        .rst          (rst),
        .rd1_tag      (rd1_tag),
        .rd2_tag      (rd2_tag),
        .rd1_data     (rd1_data),
        .rd2_data     (rd2_data),
        .cdb          (cdb),
        .preload_we   (preload_we),
        .preload_tag  (preload_tag),
        .preload_data (preload_data)
    );

    exec_unit #(
        .mul_latency (mul_latency)
    ) i_exec_unit (
        .clk      (clk),
        .rst      (rst),
        .iss      (iss.exec_unit),
        .rd1_tag  (rd1_tag),
        .rd2_tag  (rd2_tag),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .cdb      (cdb)
    );

endmodule : issue_core

// File: src/issue_if.sv
`timescale 1ns/1ps

// Issued operation from the reservation station to the execution unit
// No back-pressure, the CDB slot is reserved before issue
interface issue_if
    import ooo_params_pkg::*, ooo_types_pkg::*;
();
    logic              valid;
    op_e               op;
    logic [preg_w-1:0] src1;
    logic [preg_w-1:0] src2;
    logic              use_imm;
    logic [imm_w-1:0]  imm;
    logic [preg_w-1:0] dest;

    // Station side registers every field
    modport reservation_station (
        output valid, op, src1, src2, use_imm, imm, dest
    );

    // Execution side consumes the operation in the cycle after issue
    modport exec_unit (
        input valid, op, src1, src2, use_imm, imm, dest
    );

endinterface : issue_if

// File: src/ooo_params_pkg.sv
package ooo_params_pkg;

    // Data path width of the integer core
    parameter int xlen = 32;

    // Physical register space seen by the back end
    // Tag 0 is the hardwired zero register
    parameter int preg_count = 64;

    // Tag width follows from the register count
    parameter int preg_w = $clog2(preg_count);

    // Immediate field as delivered by rename, sign extended in the execution unit
    parameter int imm_w = 12;

endpackage : ooo_params_pkg

// File: src/ooo_types_pkg.sv
package ooo_types_pkg;

    import ooo_params_pkg::*;

    // Operation codes understood by the execution unit
    // Everything except op_mul completes in the one-cycle ALU
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_xor  = 3'd3,
        op_addi = 3'd4,
        op_mul  = 3'd5
    } op_e;

    // One renamed operation as handed over by the rename stage
    // Ready flags say the source value already sits in the register file
    typedef struct packed {
        op_e               op;
        logic [preg_w-1:0] src1;
        logic              src1_ready;
        logic [preg_w-1:0] src2;
        logic              src2_ready;
        // Immediate replaces source 2 when set
        logic              use_imm;
        logic [imm_w-1:0]  imm;
        logic [preg_w-1:0] dest;
    } dispatch_t;

    // Common data bus broadcast
    // Writes the register file and wakes waiting entries
    typedef struct packed {
        logic              valid;
        logic [preg_w-1:0] tag;
        logic [xlen-1:0]   data;
    } cdb_t;

endpackage : ooo_types_pkg

// File: src/phys_reg_file.sv
`timescale 1ns/1ps

module phys_reg_file
    import ooo_params_pkg::*, ooo_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [preg_w-1:0] rd1_tag,
    input  logic [preg_w-1:0] rd2_tag,
    output logic [xlen-1:0]   rd1_data,
    output logic [xlen-1:0]   rd2_data,
    input  cdb_t              cdb,
    input  logic              preload_we,
    input  logic [preg_w-1:0] preload_tag,
    input  logic [xlen-1:0]   preload_data
);

    // Register storage, contents are undefined until written
    logic [xlen-1:0] regs [preg_count];

    // Two write ports, both land at the same edge
    // Writes to tag 0 are dropped, no writes while in reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            if (cdb.valid && cdb.tag != '0) begin
                regs[cdb.tag] <= cdb.data;
            end
            if (preload_we && preload_tag != '0) begin
                regs[preload_tag] <= preload_data;
            end
        end
    end

    // Asynchronous reads
    // Tag 0 reads as zero
    assign rd1_data = (rd1_tag == '0) ? '0 : regs[rd1_tag];
    assign rd2_data = (rd2_tag == '0) ? '0 : regs[rd2_tag];

    // Preload traffic and CDB results never target the same register together
    a_no_write_clash: assert property (@(posedge clk) disable iff (rst)
        !(cdb.valid && preload_we && cdb.tag == preload_tag));

endmodule : phys_reg_file

// File: src/reservation_station.sv
`timescale 1ns/1ps

module reservation_station
    import ooo_params_pkg::*, ooo_types_pkg::*;
#(
    parameter int rs_depth    = 8,
    parameter int mul_latency = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        disp_valid,
    input  dispatch_t                   disp,
    input  cdb_t                        cdb,
    output logic                        disp_ready,
    issue_if.reservation_station        iss
);

    localparam int idx_w = $clog2(rs_depth);
    localparam int cnt_w = $clog2(rs_depth + 1);

    // Entry table, valid bits are control state, payload has no reset
    logic [rs_depth-1:0]    ent_valid;
    dispatch_t              ent [rs_depth];

    // CDB slot reservations, bit j covers the load at the (j+2)th upcoming edge
    // Only multiplies reserve, ALU ops check bit 0 before issue
    logic [mul_latency-2:0] slot_resv;

    logic [cnt_w-1:0]       occupied;
    logic                   accept;
    logic                   free_found;
    logic [idx_w-1:0]       free_idx;
    logic                   sel_found;
    logic [idx_w-1:0]       sel_idx;
    logic                   sel_is_mul;
    dispatch_t              disp_woken;

    // Occupancy count drives the full flag
    always_comb begin
        occupied = '0;
        for (int i = 0; i < rs_depth; i++) begin
            occupied = occupied + cnt_w'(ent_valid[i]);
        end
    end

    assign disp_ready = (occupied != cnt_w'(rs_depth));
    assign accept     = disp_valid && disp_ready;

    // Lowest free slot takes the incoming operation
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_found = 1'b1;
                free_idx   = idx_w'(i);
            end
        end
    end

    // Incoming operation also snoops the CDB in its acceptance cycle
    always_comb begin
        disp_woken = disp;
        if (cdb.valid && cdb.tag == disp.src1) begin
            disp_woken.src1_ready = 1'b1;
        end
        if (cdb.valid && cdb.tag == disp.src2) begin
            disp_woken.src2_ready = 1'b1;
        end
    end

    // Oldest-index select among ready entries with a free CDB slot
    // A multiply lands beyond every existing reservation, so it is always slot free
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (ent_valid[i] && ent[i].src1_ready && ent[i].src2_ready &&
                (ent[i].op == op_mul || !slot_resv[0])) begin
                sel_found = 1'b1;
                sel_idx   = idx_w'(i);
            end
        end
    end

    assign sel_is_mul = (ent[sel_idx].op == op_mul);

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
            slot_resv <= '0;
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= sel_found;
            // Age reservations by one edge, then claim the multiply's landing slot
            slot_resv <= slot_resv >> 1;
            if (sel_found && sel_is_mul) begin
                slot_resv[mul_latency-2] <= 1'b1;
            end
            if (sel_found) begin
                ent_valid[sel_idx] <= 1'b0;
            end
            // Free slot is never the selected one, both updates can coexist
            if (accept) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    // Payload and wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (cdb.valid && ent[i].src1 == cdb.tag) begin
                ent[i].src1_ready <= 1'b1;
            end
            if (cdb.valid && ent[i].src2 == cdb.tag) begin
                ent[i].src2_ready <= 1'b1;
            end
        end
        if (accept) begin
            ent[free_idx] <= disp_woken;
        end
        if (sel_found) begin
            iss.op      <= ent[sel_idx].op;
            iss.src1    <= ent[sel_idx].src1;
            iss.src2    <= ent[sel_idx].src2;
            iss.use_imm <= ent[sel_idx].use_imm;
            iss.imm     <= ent[sel_idx].imm;
            iss.dest    <= ent[sel_idx].dest;
        end
    end

    // Occupancy grows by one per acceptance and shrinks by one per issue
    // An acceptance into a live entry would break the count
    a_accept_has_room: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> occupied == $past(occupied) + cnt_w'($past(accept))
                             - cnt_w'($past(sel_found)));

    // An entry still waiting on an operand stays in the table
    for (genvar g = 0; g < rs_depth; g++) begin : g_wait
        a_issue_ready: assert property (@(posedge clk) disable iff (rst)
            (ent_valid[g] && !(ent[g].src1_ready && ent[g].src2_ready))
                |=> ent_valid[g]);
    end

    // An ALU issue mul_latency-1 cycles after a multiply would share its CDB slot
    a_slot_unique: assert property (@(posedge clk) disable iff (rst)
        (iss.valid && iss.op == op_mul) |->
            ##(mul_latency - 1) !(iss.valid && iss.op != op_mul));

endmodule : reservation_station

// File: tb/tb_issue_core.sv
`timescale 1ns/1ps

module tb_issue_core
    import ooo_params_pkg::*, ooo_types_pkg::*;
;

    localparam int rs_depth       = 8;
    localparam int mul_latency    = 3;
    localparam int first_free_tag = 16;
    // Directed tests 10 + 8 + 16 + 14 + 3 operations, random run 300
    localparam int planned_ops    = 351;
    localparam int timeout_cycles = 40 * planned_ops + 200;

    logic              clk;
    logic              rst;
    logic              dispatch_valid;
    op_e               dispatch_op;
    logic [preg_w-1:0] dispatch_src1;
    logic              dispatch_src1_ready;
    logic [preg_w-1:0] dispatch_src2;
    logic              dispatch_src2_ready;
    logic              dispatch_use_imm;
    logic [imm_w-1:0]  dispatch_imm;
    logic [preg_w-1:0] dispatch_dest;
    logic              dispatch_ready;
    logic              preload_we;
    logic [preg_w-1:0] preload_tag;
    logic [xlen-1:0]   preload_data;
    logic              result_valid;
    logic [preg_w-1:0] result_tag;
    logic [xlen-1:0]   result_data;

    // Rename model state, one slot per physical register
    logic [xlen-1:0]   model_val [preg_count];
    bit                avail     [preg_count];
    bit                pending   [preg_count];
    int                next_tag;
    int                outstanding;
    int                results_seen;
    int                mismatches;
    int                other_errors;
    int                cycle_count;
    bit                saw_full;

    issue_core #(
        .rs_depth    (rs_depth),
        .mul_latency (mul_latency)
    ) i_issue_core (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Value each operation should produce, worked out from the ISA meaning of the opcode
    function automatic logic [xlen-1:0] reference_result(op_e op, logic [xlen-1:0] a,
                                                         logic [xlen-1:0] b,
                                                         logic [imm_w-1:0] imm);
        logic [xlen-1:0] imm_sext;
        logic [2*xlen-1:0] product;
        imm_sext = {{(xlen - imm_w){imm[imm_w-1]}}, imm};
        product  = a * b;
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_xor:  return a ^ b;
            op_addi: return a + imm_sext;
            // Only the low word of the product is architecturally visible
            op_mul:  return product[xlen-1:0];
            default: return '0;
        endcase
    endfunction

    task automatic check_value(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [preg_w-1:0] pick_preloaded();
        return preg_w'(1 + ($urandom % 15));
    endfunction

    // Hand one operation to the DUT, holding it while dispatch_ready is low
    task automatic send_op(input op_e op, input logic [preg_w-1:0] s1,
                           input logic [preg_w-1:0] s2, input logic use_imm,
                           input logic [imm_w-1:0] imm, output logic [preg_w-1:0] dest);
        logic accepted;
        dest = preg_w'(next_tag);
        next_tag++;
        model_val[dest] = reference_result(op, model_val[s1], model_val[s2], imm);
        avail[dest]     = 1'b0;
        pending[dest]   = 1'b1;
        outstanding++;
        dispatch_valid   = 1'b1;
        dispatch_op      = op;
        dispatch_src1    = s1;
        dispatch_src2    = s2;
        dispatch_use_imm = use_imm;
        dispatch_imm     = imm;
        dispatch_dest    = dest;
        accepted = 1'b0;
        while (!accepted) begin
            // Ready flags follow results seen so far, refreshed while held
            dispatch_src1_ready = avail[s1];
            dispatch_src2_ready = avail[s2];
            @(negedge clk);
            accepted = dispatch_ready;
            if (!accepted) begin
                saw_full = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_all_returned();
        while (outstanding != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Destination tags are reused only after every earlier result came back
    task automatic recycle_tags();
        wait_all_returned();
        next_tag = first_free_tag;
    endtask

    task automatic wait_for_result(logic [preg_w-1:0] tag);
        do begin
            @(posedge clk);
            #1;
        end while (!(result_valid && result_tag == tag));
    endtask

    task automatic send_random_op();
        op_e               op;
        logic [preg_w-1:0] s1;
        logic [preg_w-1:0] s2;
        logic [preg_w-1:0] dest;
        if (next_tag == preg_count) begin
            recycle_tags();
        end
        op = op_e'($urandom % 6);
        // Sources come from tag 0, preloads or results of this tag generation
        s1 = preg_w'($urandom % next_tag);
        s2 = (op == op_addi) ? '0 : preg_w'($urandom % next_tag);
        send_op(op, s1, s2, op == op_addi, imm_w'($urandom), dest);
    endtask

    task automatic preload_regs();
        for (int t = 1; t < first_free_tag; t++) begin
            preload_we   = 1'b1;
            preload_tag  = preg_w'(t);
            preload_data = $urandom;
            model_val[t] = preload_data;
            avail[t]     = 1'b1;
            @(posedge clk);
            #1;
        end
        preload_we = 1'b0;
    endtask

    // Scoreboard, samples the CDB at the falling edge where it is stable
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            if (!pending[result_tag]) begin
                other_errors++;
                $display("result for tag %0d was not expected or came back twice", result_tag);
            end else begin
                check_value($sformatf("result_data tag %0d", result_tag), result_data,
                            model_val[result_tag]);
                pending[result_tag] = 1'b0;
                avail[result_tag]   = 1'b1;
                outstanding--;
                results_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("run timed out after %0d cycles with %0d results outstanding",
                     cycle_count, outstanding);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [preg_w-1:0] t_a;
        logic [preg_w-1:0] t_b;
        logic [preg_w-1:0] t_c;
        logic [preg_w-1:0] t_d;
        logic [preg_w-1:0] m;
        logic [preg_w-1:0] dummy;
        void'($urandom(32'he440_b60f));
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op = op_add;
        dispatch_src1 = '0;
        dispatch_src1_ready = 1'b0;
        dispatch_src2 = '0;
        dispatch_src2_ready = 1'b0;
        dispatch_use_imm = 1'b0;
        dispatch_imm = '0;
        dispatch_dest = '0;
        preload_we = 1'b0;
        preload_tag = '0;
        preload_data = '0;
        for (int t = 0; t < preg_count; t++) begin
            model_val[t] = '0;
            avail[t]     = (t == 0);
            pending[t]   = 1'b0;
        end
        next_tag = first_free_tag;
        outstanding = 0;
        results_seen = 0;
        mismatches = 0;
        other_errors = 0;
        cycle_count = 0;
        saw_full = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle state straight out of reset
        check_value("dispatch_ready", xlen'(dispatch_ready), 1);
        check_value("result_valid", xlen'(result_valid), 0);
        preload_regs();

        // Independent ALU operations on preloaded registers
        for (int k = 0; k < 5; k++) begin
            repeat (2) begin
                send_op(op_e'(k), pick_preloaded(), pick_preloaded(), k == 4,
                        imm_w'($urandom), dummy);
            end
        end

        // Dependency chain, then sources broadcast in the cycle of acceptance
        recycle_tags();
        send_op(op_add, 1, 2, 1'b0, '0, t_a);
        send_op(op_sub, t_a, 3, 1'b0, '0, t_b);
        send_op(op_xor, t_b, t_a, 1'b0, '0, t_c);
        send_op(op_addi, t_c, 0, 1'b1, 12'h801, t_d);
        send_op(op_and, t_d, t_b, 1'b0, '0, t_a);
        wait_for_result(t_a);
        send_op(op_add, t_a, 4, 1'b0, '0, dummy);
        send_op(op_mul, 5, 6, 1'b0, '0, t_b);
        wait_for_result(t_b);
        send_op(op_sub, 7, t_b, 1'b0, '0, dummy);

        // Mixed multiplies and ALU operations
        recycle_tags();
        repeat (16) begin
            send_op(($urandom % 2) ? op_mul : op_e'($urandom % 4), pick_preloaded(),
                    pick_preloaded(), 1'b0, '0, dummy);
        end

        // A multiply chain holds back enough dependents to fill the table
        recycle_tags();
        saw_full = 1'b0;
        send_op(op_mul, 1, 2, 1'b0, '0, m);
        repeat (3) begin
            send_op(op_mul, m, 3, 1'b0, '0, m);
        end
        repeat (rs_depth + 2) begin
            send_op(op_e'($urandom % 4), m, pick_preloaded(), 1'b0, '0, dummy);
        end
        wait_all_returned();
        if (!saw_full) begin
            other_errors++;
            $display("dispatch_ready never dropped while the table was full");
        end

        // Tag 0 sources read as zero
        recycle_tags();
        send_op(op_add, 0, 9, 1'b0, '0, dummy);
        send_op(op_mul, 7, 0, 1'b0, '0, dummy);
        send_op(op_addi, 0, 0, 1'b1, 12'hf9c, dummy);

        // Random run
        recycle_tags();
        repeat (300) begin
            send_random_op();
        end
        wait_all_returned();

        for (int t = 0; t < preg_count; t++) begin
            if (pending[t]) begin
                other_errors++;
                $display("tag %0d never returned a result", t);
            end
        end
        $display("%0d results checked, %0d mismatches, %0d other errors",
                 results_seen, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_issue_core
